/* common/lane_split_pkg.sv */
package lane_split_pkg;

  // Lane geometry
  localparam int lane_count = 4;
  localparam int lane_width = 16;
  // One keep bit per byte of a lane
  localparam int lane_keep_width = lane_width / 8;

  // Wide input stream
  localparam int in_width = lane_count * lane_width;
  localparam int in_keep_width = lane_count * lane_keep_width;

  // Width of each of id, dest and user
  localparam int side_width = 8;

  // Sideband copied unchanged to every lane
  typedef struct packed {
    logic                  last;
    logic [side_width-1:0] id;
    logic [side_width-1:0] dest;
    logic [side_width-1:0] user;
  } side_t;

  // Full wide beat, as held in the input skid buffer
  typedef struct packed {
    logic [in_width-1:0]      data;
    logic [in_keep_width-1:0] keep;
    side_t                    side;
  } in_payload_t;

  // One lane's share of a wide beat
  typedef struct packed {
    logic [lane_width-1:0]      data;
    logic [lane_keep_width-1:0] keep;
    side_t                      side;
  } lane_payload_t;

endpackage

/* axis_skid/axis_skid_buffer.sv */
`timescale 1ns/100ps

module axis_skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,

  // Upstream side
  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,

  // Downstream side
  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  // Output stage
  logic     m_valid_reg;
  payload_t m_data_reg;

  // Skid stage, catches the beat accepted while the output stalls
  logic     skid_valid_reg;
  payload_t skid_data_reg;

  // Registered ready
  logic     s_ready_reg;
  logic     s_ready_early;

  // Load strobes
  logic     load_out_from_in;
  logic     load_out_from_skid;
  logic     load_skid;

  always_comb begin
    // Keep accepting while the skid slot stays free after this edge
    s_ready_early = m_ready || (!skid_valid_reg && (!m_valid_reg || !s_valid));

    load_out_from_in   = 1'b0;
    load_out_from_skid = 1'b0;
    load_skid          = 1'b0;

    if (s_ready_reg) begin
      // Output empty or draining, input goes straight to output
      if (m_ready || !m_valid_reg) begin
        load_out_from_in = 1'b1;
      end else begin
        // Output stalled, park the beat in the skid slot
        load_skid = 1'b1;
      end
    end else if (m_ready) begin
      // Upstream blocked, refill output from skid slot
      load_out_from_skid = 1'b1;
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      s_ready_reg    <= 1'b1;
      m_valid_reg    <= 1'b0;
      skid_valid_reg <= 1'b0;
    end else begin
      s_ready_reg <= s_ready_early;

      if (load_out_from_in) begin
        m_valid_reg <= s_valid;
      end else if (load_out_from_skid) begin
        m_valid_reg <= skid_valid_reg;
      end

      if (load_skid) begin
        skid_valid_reg <= s_valid;
      end else if (load_out_from_skid) begin
        skid_valid_reg <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (load_out_from_in) begin
      m_data_reg <= s_data;
    end else if (load_out_from_skid) begin
      m_data_reg <= skid_data_reg;
    end

    if (load_skid) begin
      skid_data_reg <= s_data;
    end
  end

  assign s_ready = s_ready_reg;
  assign m_valid = m_valid_reg;
  assign m_data  = m_data_reg;

endmodule

/* src/lane_lock_control.sv */
`timescale 1ns/100ps

module lane_lock_control
  import lane_split_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,

  // Held wide beat
  input  logic                     held_valid,
  input  logic [in_keep_width-1:0] held_keep,
  output logic                     held_ready,

  // Per-lane handshake
  output logic [lane_count-1:0]    lane_valid,
  input  logic [lane_count-1:0]    lane_ready
);

  // Lanes already done with the current wide beat
  logic [lane_count-1:0] lock_reg;
  logic [lane_count-1:0] lock_next;

  // Lanes with at least one kept byte
  logic [lane_count-1:0] lane_active;

  // Lane transfers on this edge
  logic [lane_count-1:0] lane_xfer;

  // Every data lane is locked or transferring now
  logic                  beat_done;

  // Keep OR per lane
  for (genvar k = 0; k < lane_count; k++) begin : g_active
    assign lane_active[k] = |held_keep[k*lane_keep_width +: lane_keep_width];
  end

  // Offer a lane only while it still owes its slice
  assign lane_valid = {lane_count{held_valid}} & lane_active & ~lock_reg;

  assign lane_xfer = lane_valid & lane_ready;

  // Idle lanes count as done, so an all-zero keep beat drops at once
  assign beat_done = &(~lane_active | lock_reg | lane_xfer);

  assign held_ready = beat_done;

  // Locks clear on release, otherwise collect this edge's transfers
  always_comb begin
    if (held_valid && beat_done) begin
      lock_next = '0;
    end else begin
      lock_next = lock_reg | lane_xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_reg <= '0;
    end else begin
      lock_next_apply: begin
        lock_reg <= lock_next;
      end
    end
  end

endmodule

/* src/lane_splitter.sv */
`timescale 1ns/100ps

module lane_splitter
  import lane_split_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst,

  // Wide input stream
  input  logic [in_width-1:0]              s_tdata,
  input  logic [in_keep_width-1:0]         s_tkeep,
  input  logic                             s_tlast,
  input  logic [side_width-1:0]            s_tid,
  input  logic [side_width-1:0]            s_tdest,
  input  logic [side_width-1:0]            s_tuser,
  input  logic                             s_tvalid,
  output logic                             s_tready,

  // Lane outputs, lane 0 in the low bits
  output logic [in_width-1:0]              m_tdata,
  output logic [in_keep_width-1:0]         m_tkeep,
  output logic [lane_count-1:0]            m_tlast,
  output logic [lane_count*side_width-1:0] m_tid,
  output logic [lane_count*side_width-1:0] m_tdest,
  output logic [lane_count*side_width-1:0] m_tuser,
  output logic [lane_count-1:0]            m_tvalid,
  input  logic [lane_count-1:0]            m_tready
);

  // Packed input beat
  in_payload_t   s_payload;

  // Beat sitting at the skid buffer output
  in_payload_t   held_payload;
  logic          held_valid;
  logic          held_ready;

  // Per-lane view of the held beat
  lane_payload_t lane_payload [lane_count];

  // Gather the loose input fields
  assign s_payload.data      = s_tdata;
  assign s_payload.keep      = s_tkeep;
  assign s_payload.side.last = s_tlast;
  assign s_payload.side.id   = s_tid;
  assign s_payload.side.dest = s_tdest;
  assign s_payload.side.user = s_tuser;

  // Input register stage, ready comes from a flop
  axis_skid_buffer #(
    .payload_t (in_payload_t)
  ) in_skid (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_tvalid),
    .s_ready (s_tready),
    .s_data  (s_payload),
    .m_valid (held_valid),
    .m_ready (held_ready),
    .m_data  (held_payload)
  );

  // Lane valids and beat release
  lane_lock_control lock_ctrl (
    .clk        (clk),
    .rst        (rst),
    .held_valid (held_valid),
    .held_keep  (held_payload.keep),
    .held_ready (held_ready),
    .lane_valid (m_tvalid),
    .lane_ready (m_tready)
  );

  for (genvar k = 0; k < lane_count; k++) begin : g_lane
    // Slice of data and keep for lane k
    assign lane_payload[k].data = held_payload.data[k*lane_width +: lane_width];
    assign lane_payload[k].keep = held_payload.keep[k*lane_keep_width +: lane_keep_width];

    // Same sideband on every lane
    assign lane_payload[k].side = held_payload.side;

    // Flatten onto the output vectors
    assign m_tdata[k*lane_width +: lane_width]           = lane_payload[k].data;
    assign m_tkeep[k*lane_keep_width +: lane_keep_width] = lane_payload[k].keep;
    assign m_tlast[k]                                    = lane_payload[k].side.last;
    assign m_tid[k*side_width +: side_width]             = lane_payload[k].side.id;
    assign m_tdest[k*side_width +: side_width]           = lane_payload[k].side.dest;
    assign m_tuser[k*side_width +: side_width]           = lane_payload[k].side.user;
  end

endmodule

/* verification/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// First error ends the run
task automatic stop_with_failure(input string why);
  $display("%s", why);
  $display("Simulation FAILED");
  $fatal(1, "Stopped at first error");
endtask

// One field of a lane beat did not match
task automatic report_field(input string name, input int lane,
                            input logic [31:0] exp, input logic [31:0] got);
  stop_with_failure($sformatf("FAIL %s lane %0d: expected %h, got %h",
                              name, lane, exp, got));
endtask

// Lane beat against its expected slice and sideband
task automatic check_lane(input int lane, input lane_payload_t exp, input lane_payload_t got);
  if (got.data !== exp.data)
    report_field("m_tdata", lane, 32'(exp.data), 32'(got.data));
  if (got.keep !== exp.keep)
    report_field("m_tkeep", lane, 32'(exp.keep), 32'(got.keep));
  if (got.side.last !== exp.side.last)
    report_field("m_tlast", lane, 32'(exp.side.last), 32'(got.side.last));
  if (got.side.id !== exp.side.id)
    report_field("m_tid", lane, 32'(exp.side.id), 32'(got.side.id));
  if (got.side.dest !== exp.side.dest)
    report_field("m_tdest", lane, 32'(exp.side.dest), 32'(got.side.dest));
  if (got.side.user !== exp.side.user)
    report_field("m_tuser", lane, 32'(exp.side.user), 32'(got.side.user));
endtask

// Beats seen on a lane over the whole run
task automatic check_count(input int lane, input int exp, input int got);
  if (got != exp)
    report_field("beat count", lane, exp, got);
endtask

// Lane valid vector
task automatic check_valid(input logic [lane_count-1:0] exp, input logic [lane_count-1:0] got);
  if (got !== exp)
    stop_with_failure($sformatf("FAIL m_tvalid: expected %h, got %h", exp, got));
endtask

// Input ready
task automatic check_ready(input logic exp, input logic got);
  if (got !== exp)
    stop_with_failure($sformatf("FAIL s_tready: expected %h, got %h", exp, got));
endtask

`endif

/* verification/tb_lane_splitter.sv */
`timescale 1ns/100ps

module tb_lane_splitter
  import lane_split_pkg::*;
();

  localparam int table_len      = 24;
  localparam int timeout_cycles = table_len * lane_count * 40;
  // Beat at which all lanes stall for a while
  localparam int stall_idx      = 12;

  // One table row with the mask of lanes expected to carry data
  typedef struct packed {
    logic [in_width-1:0]      data;
    logic [in_keep_width-1:0] keep;
    logic                     last;
    logic [side_width-1:0]    id;
    logic [side_width-1:0]    dest;
    logic [side_width-1:0]    user;
    logic [lane_count-1:0]    mask;
  } stim_t;

  logic                             clk = 1'b0;
  logic                             rst;
  logic [in_width-1:0]              s_tdata;
  logic [in_keep_width-1:0]         s_tkeep;
  logic                             s_tlast;
  logic [side_width-1:0]            s_tid;
  logic [side_width-1:0]            s_tdest;
  logic [side_width-1:0]            s_tuser;
  logic                             s_tvalid;
  logic                             s_tready;
  logic [in_width-1:0]              m_tdata;
  logic [in_keep_width-1:0]         m_tkeep;
  logic [lane_count-1:0]            m_tlast;
  logic [lane_count*side_width-1:0] m_tid;
  logic [lane_count*side_width-1:0] m_tdest;
  logic [lane_count*side_width-1:0] m_tuser;
  logic [lane_count-1:0]            m_tvalid;
  logic [lane_count-1:0]            m_tready;

  stim_t         stim [table_len];
  // Per-lane scoreboard with the input beat index as tag
  lane_payload_t exp_q [lane_count][$];
  int            tag_q [lane_count][$];
  int            need [table_len];
  int            delivered [table_len];
  int            got_total [lane_count];
  int            cur_idx;
  bit            saw_stall;
  integer        seed = 32'hf119;
  logic          gap_req;
  int            stall_left;
  bit            stall_used;

  `include "tb_checks.svh"

  always #10 clk = ~clk;

  lane_splitter UUT (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tlast  (s_tlast),
    .s_tid    (s_tid),
    .s_tdest  (s_tdest),
    .s_tuser  (s_tuser),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tlast  (m_tlast),
    .m_tid    (m_tid),
    .m_tdest  (m_tdest),
    .m_tuser  (m_tuser),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

  // Each row holds data, keep, last, id, dest, user and the expected lane mask
  task automatic load_table();
    stim[0]  = '{64'h0011_2233_4455_6677, 8'hff, 1'b0, 8'h01, 8'h10, 8'ha0, 4'hf};
    stim[1]  = '{64'h8899_aabb_ccdd_eeff, 8'h0f, 1'b0, 8'h01, 8'h10, 8'ha1, 4'h3};
    stim[2]  = '{64'h0123_4567_89ab_cdef, 8'hf0, 1'b1, 8'h01, 8'h10, 8'ha2, 4'hc};
    stim[3]  = '{64'hdead_beef_cafe_f00d, 8'h00, 1'b0, 8'h02, 8'h20, 8'hb0, 4'h0};
    stim[4]  = '{64'h1111_2222_3333_4444, 8'h01, 1'b0, 8'h02, 8'h20, 8'hb1, 4'h1};
    stim[5]  = '{64'h5555_6666_7777_8888, 8'h80, 1'b0, 8'h02, 8'h20, 8'hb2, 4'h8};
    stim[6]  = '{64'h9999_aaaa_bbbb_cccc, 8'h33, 1'b0, 8'h02, 8'h21, 8'hb3, 4'h5};
    stim[7]  = '{64'hdddd_eeee_ffff_0000, 8'hcc, 1'b1, 8'h02, 8'h21, 8'hb4, 4'ha};
    stim[8]  = '{64'h0f1e_2d3c_4b5a_6978, 8'hff, 1'b0, 8'h03, 8'h30, 8'hc0, 4'hf};
    stim[9]  = '{64'h8796_a5b4_c3d2_e1f0, 8'h02, 1'b0, 8'h03, 8'h30, 8'hc1, 4'h1};
    stim[10] = '{64'h1357_9bdf_2468_ace0, 8'h24, 1'b0, 8'h03, 8'h31, 8'hc2, 4'h6};
    stim[11] = '{64'hfedc_ba98_7654_3210, 8'hff, 1'b1, 8'h03, 8'h31, 8'hc3, 4'hf};
    stim[12] = '{64'h0102_0304_0506_0708, 8'hff, 1'b0, 8'h04, 8'h40, 8'hd0, 4'hf};
    stim[13] = '{64'h1112_1314_1516_1718, 8'hff, 1'b0, 8'h04, 8'h40, 8'hd1, 4'hf};
    stim[14] = '{64'h2122_2324_2526_2728, 8'h3c, 1'b0, 8'h04, 8'h41, 8'hd2, 4'h6};
    stim[15] = '{64'h3132_3334_3536_3738, 8'hff, 1'b0, 8'h04, 8'h41, 8'hd3, 4'hf};
    stim[16] = '{64'h4142_4344_4546_4748, 8'hc3, 1'b0, 8'h05, 8'h50, 8'he0, 4'h9};
    stim[17] = '{64'h5152_5354_5556_5758, 8'h00, 1'b1, 8'h05, 8'h50, 8'he1, 4'h0};
    stim[18] = '{64'h6162_6364_6566_6768, 8'h00, 1'b0, 8'h05, 8'h51, 8'he2, 4'h0};
    stim[19] = '{64'h7172_7374_7576_7778, 8'h40, 1'b0, 8'h05, 8'h51, 8'he3, 4'h8};
    stim[20] = '{64'h8182_8384_8586_8788, 8'h10, 1'b0, 8'h06, 8'h60, 8'hf0, 4'h4};
    stim[21] = '{64'h9192_9394_9596_9798, 8'h04, 1'b0, 8'h06, 8'h60, 8'hf1, 4'h2};
    stim[22] = '{64'ha1a2_a3a4_a5a6_a7a8, 8'hfe, 1'b0, 8'h06, 8'h61, 8'hf2, 4'hf};
    stim[23] = '{64'hb1b2_b3b4_b5b6_b7b8, 8'hff, 1'b1, 8'h06, 8'h61, 8'hf3, 4'hf};
  endtask

  function automatic int pending_beats();
    int n;
    n = 0;
    for (int k = 0; k < lane_count; k++)
      n += exp_q[k].size();
    return n;
  endfunction

  // Beats lane k owes over the whole table
  function automatic int expected_beats(input int k);
    int n;
    n = 0;
    for (int j = 0; j < table_len; j++)
      if (stim[j].mask[k])
        n++;
    return n;
  endfunction

  // Offer one table row and hold it until accepted
  task automatic send_beat(input int i);
    if (gap_req) begin
      s_tvalid <= 1'b0;
      @(posedge clk);
      #2;
    end
    s_tdata  <= stim[i].data;
    s_tkeep  <= stim[i].keep;
    s_tlast  <= stim[i].last;
    s_tid    <= stim[i].id;
    s_tdest  <= stim[i].dest;
    s_tuser  <= stim[i].user;
    s_tvalid <= 1'b1;
    cur_idx  <= i;
    // Ready is a flop, so its mid-cycle value holds at the edge
    @(negedge clk);
    while (!s_tready)
      @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  // Random lane back-pressure and input gaps plus one forced stall window
  initial begin : ready_gen
    logic [31:0] r;
    m_tready = '0;
    gap_req  = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      r = $random(seed);
      gap_req <= (r[9:8] == 2'b00);
      if (stall_left > 0) begin
        m_tready   <= '0;
        stall_left = stall_left - 1;
      end else begin
        m_tready <= r[3:0] | r[7:4];
      end
      if (cur_idx == stall_idx && !stall_used) begin
        stall_left = 10;
        stall_used = 1'b1;
      end
    end
  end

  // Scoreboard sampled mid-cycle
  always @(negedge clk) begin : monitor
    lane_payload_t exp;
    lane_payload_t got;
    int            tag;
    if (!rst) begin
      for (int k = 0; k < lane_count; k++) begin
        if (m_tvalid[k] && m_tready[k]) begin
          if (exp_q[k].size() == 0)
            stop_with_failure($sformatf("Lane %0d delivered a beat nobody sent", k));
          exp           = exp_q[k].pop_front();
          tag           = tag_q[k].pop_front();
          got.data      = m_tdata[k*lane_width +: lane_width];
          got.keep      = m_tkeep[k*lane_keep_width +: lane_keep_width];
          got.side.last = m_tlast[k];
          got.side.id   = m_tid[k*side_width +: side_width];
          got.side.dest = m_tdest[k*side_width +: side_width];
          got.side.user = m_tuser[k*side_width +: side_width];
          check_lane(k, exp, got);
          // No lane may run ahead of an unfinished wide beat
          for (int j = 0; j < tag; j++)
            if (delivered[j] != need[j])
              stop_with_failure($sformatf("Lane %0d sent beat %0d before beat %0d was done",
                                          k, tag, j));
          delivered[tag]++;
          got_total[k]++;
        end
      end
      // Expected slices for each data lane of an accepted input beat
      if (s_tvalid && s_tready) begin
        for (int k = 0; k < lane_count; k++) begin
          if (stim[cur_idx].mask[k]) begin
            exp.data = stim[cur_idx].data[k*lane_width +: lane_width];
            exp.keep = stim[cur_idx].keep[k*lane_keep_width +: lane_keep_width];
            exp.side = '{stim[cur_idx].last, stim[cur_idx].id,
                         stim[cur_idx].dest, stim[cur_idx].user};
            exp_q[k].push_back(exp);
            tag_q[k].push_back(cur_idx);
          end
        end
      end
      if (s_tvalid && !s_tready)
        saw_stall = 1'b1;
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    stop_with_failure($sformatf("Timeout, lanes did not drain within %0d clock cycles",
                                timeout_cycles));
  end

  initial begin : main
    rst      = 1'b1;
    s_tdata  = '0;
    s_tkeep  = '0;
    s_tlast  = 1'b0;
    s_tid    = '0;
    s_tdest  = '0;
    s_tuser  = '0;
    s_tvalid = 1'b0;
    cur_idx  = 0;
    load_table();
    for (int j = 0; j < table_len; j++)
      need[j] = $countones(stim[j].mask);
    repeat (8) @(posedge clk);
    #2;
    rst <= 1'b0;
    // Idle after reset
    @(negedge clk);
    check_valid('0, m_tvalid);
    check_ready(1'b1, s_tready);
    @(posedge clk);
    #2;
    for (int i = 0; i < table_len; i++)
      send_beat(i);
    s_tvalid <= 1'b0;
    while (pending_beats() != 0)
      @(negedge clk);
    // A few quiet cycles catch stray lane beats
    repeat (4) @(negedge clk);
    for (int k = 0; k < lane_count; k++)
      check_count(k, expected_beats(k), got_total[k]);
    if (!saw_stall) begin
      stop_with_failure("Input ready never dropped under sustained back-pressure");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

/* build.f */
+incdir+verification
common/lane_split_pkg.sv
axis_skid/axis_skid_buffer.sv
src/lane_lock_control.sv
src/lane_splitter.sv
verification/tb_lane_splitter.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the lane splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f build.f \
  --top-module tb_lane_splitter -Mdir obj_dir -o tb_lane_splitter > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_lane_splitter > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi
exit 0
